// ==== tb.f ====
+incdir+hw
hw/gui_pkg.sv
hw/button_touch.sv
hw/bitmap_streamer.sv
hw/draw_sequencer.sv
hw/gui_top.sv
tb/gui_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = gui_tb
FILELIST = tb.f

BUILD   = obj_dir
BIN     = $(BUILD)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST))
HEADERS = hw/gui_params.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/gui_tb.sv ====
// testbench for the touch button panel: tft responder, reference model and assertions
`default_nettype none
`include "gui_params.svh"

module gui_tb
    import gui_pkg::*;
;

    localparam int XFERS           = 5;   // buttons drawn over all passes
    localparam int WATCHDOG_CYCLES = XFERS * 500 + 1000;
    localparam int NPIX            = `GUI_BMP_W * `GUI_BMP_H;

    logic                    clk;
    logic                    arstn;
    touch_t                  touch;
    logic                    draw;
    logic                    cnext;
    logic                    tft_done;
    logic                    update;
    logic                    tft_draw;
    logic                    drawdone;
    rect_t                   window;
    logic [`GUI_COLOR_W-1:0] color;
    logic                    start_state;
    logic                    left_touched;
    logic                    right_touched;

    int          errors = 0;
    int          xfers = 0;
    logic [31:0] rnd;
    logic        long_wait;

    // reference model, 0 idle then 1..3 for start, left, right
    logic [1:0]              m_cur;
    logic                    m_busy;
    logic [2:0]              m_pend;
    logic [2:0]              m_touched;
    logic                    m_start_d;
    logic                    m_state;
    logic [8:0]              m_px;
    logic [2:0]              m_sel;
    logic                    m_load;
    logic                    start_rise;
    logic                    hold_q;
    rect_t                   win_q;
    logic                    exp_drawdone;
    logic                    exp_tft_draw;
    rect_t                   exp_window;
    logic [`GUI_COLOR_W-1:0] exp_color;

    gui_top dut (
        .clk           (clk),
        .arstn         (arstn),
        .touch         (touch),
        .draw          (draw),
        .cnext         (cnext),
        .tft_done      (tft_done),
        .update        (update),
        .tft_draw      (tft_draw),
        .drawdone      (drawdone),
        .window        (window),
        .color         (color),
        .start_state   (start_state),
        .left_touched  (left_touched),
        .right_touched (right_touched)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic in_button(input touch_t t, input int y0);
        return t.touch && (int'(t.x) >= `GUI_BTN_X) && (int'(t.x) < `GUI_BTN_X + `GUI_BTN_W)
               && (int'(t.y) >= y0) && (int'(t.y) < y0 + `GUI_BTN_H);
    endfunction

    function automatic rect_t window_for(input logic [1:0] btn);
        rect_t r;
        int    y0;
        r = '0;
        case (btn)
            2'd1:    y0 = `GUI_START_Y;
            2'd2:    y0 = `GUI_LEFT_Y;
            default: y0 = `GUI_RIGHT_Y;
        endcase
        if (btn != 2'd0) begin
            r.xstart = `GUI_COORD_W'(`GUI_BTN_X + `GUI_BMP_OFS);
            r.xend   = `GUI_COORD_W'(`GUI_BTN_X + `GUI_BMP_OFS + `GUI_BMP_W - 1);
            r.ystart = `GUI_COORD_W'(y0 + `GUI_BMP_OFS);
            r.yend   = `GUI_COORD_W'(y0 + `GUI_BMP_OFS + `GUI_BMP_H - 1);
        end
        return r;
    endfunction

    function automatic logic [`GUI_COLOR_W-1:0] pixel_color(input logic [1:0] btn,
                                                            input logic run,
                                                            input logic [8:0] px);
        logic [5:0] row;
        logic [4:0] col;
        bmp_row_t   bits;
        row = 6'(px / 9'(`GUI_BMP_W));
        col = 5'(px % 9'(`GUI_BMP_W));
        case (btn)
            2'd1:    bits = bmp_start[run ? row + 6'(`GUI_BMP_H) : row];
            2'd2:    bits = bmp_left[row[4:0]];
            2'd3:    bits = bmp_right[row[4:0]];
            default: bits = '0;
        endcase
        return bits[5'(`GUI_BMP_W - 1) - col] ? `GUI_COLOR_FG : `GUI_COLOR_BG;   // bit 19 leftmost
    endfunction

    task automatic roll(input int n, output int v);
        rnd = lcg_next(rnd);
        v = (rnd >> 8) % n;
    endtask

    task automatic press(input int x, input int y, input int hold);
        touch.touch = 1'b1;
        touch.x     = `GUI_COORD_W'(x);
        touch.y     = `GUI_COORD_W'(y);
        repeat (hold) @(negedge clk);
        touch = '0;
        repeat (3) @(negedge clk);
    endtask

    task automatic run_draw();
        draw = 1'b1;
        @(negedge clk);
        draw = 1'b0;
        while (!drawdone) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign m_sel        = (m_cur == 2'd0) ? 3'b000 : 3'(1 << (m_cur - 2'd1));
    assign m_load       = |(m_sel & m_pend) && !m_busy;
    assign start_rise   = m_touched[0] && !m_start_d;
    assign exp_drawdone = (m_cur == 2'd0);
    assign exp_tft_draw = m_busy || m_load;
    assign exp_window   = window_for(m_cur);
    assign exp_color    = pixel_color(m_cur, m_state, m_px);

    always @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            m_cur     <= 2'd0;
            m_busy    <= 1'b0;
            m_pend    <= 3'b111;   // every button redrawn after reset
            m_touched <= 3'b000;
            m_start_d <= 1'b0;
            m_state   <= 1'b0;
            m_px      <= 9'd0;
            hold_q    <= 1'b0;
            win_q     <= '0;
        end else begin
            m_touched <= {in_button(touch, `GUI_RIGHT_Y), in_button(touch, `GUI_LEFT_Y),
                          in_button(touch, `GUI_START_Y)};
            m_start_d <= m_touched[0];
            if (start_rise) m_state <= !m_state;
            m_pend <= (m_pend & ~(m_load ? m_sel : 3'b000)) | {2'b00, start_rise};
            if (m_cur == 2'd0) begin
                if (draw) m_cur <= 2'd1;
            end else if (m_busy) begin
                if (tft_done) begin
                    m_busy <= 1'b0;
                    m_cur  <= m_cur + 2'd1;   // wraps to idle after right
                end
            end else if (m_load) begin
                m_busy <= 1'b1;
            end else begin
                m_cur <= m_cur + 2'd1;
            end
            if (m_load) m_px <= 9'd0;
            else if (cnext) m_px <= (m_px == 9'(NPIX - 1)) ? 9'd0 : m_px + 9'd1;
            hold_q <= tft_draw && !tft_done;
            win_q  <= window;
        end
    end

    a_drawdone: assert property (@(posedge clk) disable iff (!arstn) drawdone == exp_drawdone)
        else begin
            errors++;
            $display("Error at %0t: drawdone expected %b, got %b",
                     $time, $sampled(exp_drawdone), $sampled(drawdone));
        end

    a_tft_draw: assert property (@(posedge clk) disable iff (!arstn) tft_draw == exp_tft_draw)
        else begin
            errors++;
            $display("Error at %0t: tft_draw expected %b, got %b",
                     $time, $sampled(exp_tft_draw), $sampled(tft_draw));
        end

    a_update: assert property (@(posedge clk) disable iff (!arstn) update == |m_pend)
        else begin
            errors++;
            $display("Error at %0t: update expected %b, got %b",
                     $time, $sampled(|m_pend), $sampled(update));
        end

    a_window: assert property (@(posedge clk) disable iff (!arstn) window == exp_window)
        else begin
            errors++;
            $display("Error at %0t: window expected %h, got %h",
                     $time, $sampled(exp_window), $sampled(window));
        end

    // back-pressure, nothing moves before tft_done
    a_window_hold: assert property (@(posedge clk) disable iff (!arstn) hold_q |-> window == win_q)
        else begin
            errors++;
            $display("Error at %0t: window expected %h, got %h",
                     $time, $sampled(win_q), $sampled(window));
        end

    a_color: assert property (@(posedge clk) disable iff (!arstn) cnext |-> color == exp_color)
        else begin
            errors++;
            $display("Error at %0t: color expected %h, got %h",
                     $time, $sampled(exp_color), $sampled(color));
        end

    a_start_state: assert property (@(posedge clk) disable iff (!arstn) start_state == m_state)
        else begin
            errors++;
            $display("Error at %0t: start_state expected %b, got %b",
                     $time, $sampled(m_state), $sampled(start_state));
        end

    a_left: assert property (@(posedge clk) disable iff (!arstn) left_touched == m_touched[1])
        else begin
            errors++;
            $display("Error at %0t: left_touched expected %b, got %b",
                     $time, $sampled(m_touched[1]), $sampled(left_touched));
        end

    a_right: assert property (@(posedge clk) disable iff (!arstn) right_touched == m_touched[2])
        else begin
            errors++;
            $display("Error at %0t: right_touched expected %b, got %b",
                     $time, $sampled(m_touched[2]), $sampled(right_touched));
        end

    // display controller: one full bitmap, then done after a delay
    initial begin : tft_model
        int wait_cycles;
        cnext    = 1'b0;
        tft_done = 1'b0;
        forever begin
            @(negedge clk);
            if (arstn && tft_draw) begin
                @(negedge clk);   // past the load cycle
                repeat (NPIX) begin
                    cnext = 1'b1;
                    @(negedge clk);
                end
                cnext = 1'b0;
                if (long_wait) wait_cycles = 100;
                else roll(8, wait_cycles);
                repeat (wait_cycles) @(negedge clk);
                tft_done = 1'b1;
                @(negedge clk);
                tft_done = 1'b0;
                xfers++;
            end
        end
    end

    initial begin : stimulus
        int rx;
        int ry;
        arstn     = 1'b0;
        draw      = 1'b0;
        touch     = '0;
        long_wait = 1'b0;
        rnd       = 32'ha314;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;
        repeat (2) @(negedge clk);
        run_draw();   // all three pending
        roll(`GUI_BTN_W, rx);
        roll(`GUI_BTN_H, ry);
        press(`GUI_BTN_X + rx, `GUI_START_Y + ry, 4);   // held, flips once
        repeat (3) begin
            roll(200, rx);
            roll(320, ry);
            press(`GUI_BTN_X + `GUI_BTN_W + rx, ry, 2);
        end
        roll(`GUI_BTN_H, ry);
        press(`GUI_BTN_X + 5, `GUI_LEFT_Y + ry, 3);
        roll(`GUI_BTN_W, rx);
        press(`GUI_BTN_X + rx, `GUI_RIGHT_Y + 39, 3);
        run_draw();   // start only, run glyph
        roll(`GUI_BTN_W, rx);
        press(`GUI_BTN_X + rx, `GUI_START_Y, 1);
        long_wait = 1'b1;
        run_draw();
        long_wait = 1'b0;
        repeat (4) @(negedge clk);
        if (xfers != XFERS) begin
            errors++;
            $display("the display saw %0d transfers instead of %0d", xfers, XFERS);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the draw passes did not finish", WATCHDOG_CYCLES);
        $display("errors: %0d", errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/gui_top.sv ====
// gui top: three touch buttons sharing one draw sequencer and one bitmap streamer
`default_nettype none
`include "gui_params.svh"

module gui_top
    import gui_pkg::*;
(
    input  wire                     clk,
    input  wire                     arstn,
    input  wire touch_t             touch,   // screen coordinates
    input  wire                     draw,
    input  wire                     cnext,
    input  wire                     tft_done,
    output logic                    update,
    output logic                    tft_draw,
    output logic                    drawdone,
    output rect_t                   window,
    output logic [`GUI_COLOR_W-1:0] color,
    output logic                    start_state,   // 0 pause, 1 run
    output logic                    left_touched,
    output logic                    right_touched
);

    logic [2:0] pending;
    logic [2:0] ack;
    logic       load;
    gui_state_e cur;

    button_touch #(
        .RECT_Y (`GUI_START_Y),
        .TOGGLE (1'b1)
    ) u_start (
        .clk     (clk),
        .arstn   (arstn),
        .touch   (touch),
        .ack     (ack[0]),
        .touched (),
        .state   (start_state),
        .pending (pending[0])
    );

    button_touch #(
        .RECT_Y (`GUI_LEFT_Y),
        .TOGGLE (1'b0)
    ) u_left (
        .clk     (clk),
        .arstn   (arstn),
        .touch   (touch),
        .ack     (ack[1]),
        .touched (left_touched),
        .state   (),
        .pending (pending[1])
    );

    button_touch #(
        .RECT_Y (`GUI_RIGHT_Y),
        .TOGGLE (1'b0)
    ) u_right (
        .clk     (clk),
        .arstn   (arstn),
        .touch   (touch),
        .ack     (ack[2]),
        .touched (right_touched),
        .state   (),
        .pending (pending[2])
    );

    draw_sequencer u_seq (
        .clk      (clk),
        .arstn    (arstn),
        .draw     (draw),
        .tft_done (tft_done),
        .pending  (pending),
        .cur      (cur),
        .ack      (ack),
        .load     (load),
        .tft_draw (tft_draw),
        .drawdone (drawdone)
    );

    bitmap_streamer u_stream (
        .clk       (clk),
        .arstn     (arstn),
        .cur       (cur),
        .run_state (start_state),
        .load      (load),
        .cnext     (cnext),
        .window    (window),
        .color     (color)
    );

    assign update = |pending;   // any button waiting for a redraw

endmodule

`default_nettype wire

// ==== hw/draw_sequencer.sv ====
// draw sequencer: walks the three buttons and hands pending ones to the tft controller
`default_nettype none

module draw_sequencer
    import gui_pkg::*;
(
    input  wire        clk,
    input  wire        arstn,
    input  wire        draw,
    input  wire        tft_done,
    input  wire  [2:0] pending,   // start, left, right
    output gui_state_e cur,
    output logic [2:0] ack,
    output logic       load,
    output logic       tft_draw,
    output logic       drawdone
);

    gui_state_e nxt;
    logic [2:0] sel;
    logic       hit;
    logic       busy;   // transfer under way

    always_comb begin
        case (cur)
            START: begin
                sel = 3'b001;
                nxt = LEFT;
            end
            LEFT: begin
                sel = 3'b010;
                nxt = RIGHT;
            end
            RIGHT: begin
                sel = 3'b100;
                nxt = IDLE;
            end
            default: begin
                sel = 3'b000;
                nxt = draw ? START : IDLE;
            end
        endcase
    end

    assign hit = |(sel & pending);

    // first cycle of a button that needs drawing
    assign load     = hit && !busy;
    assign ack      = load ? sel : 3'b000;
    assign tft_draw = busy || load;
    assign drawdone = (cur == IDLE);

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            cur  <= IDLE;
            busy <= 1'b0;
        end else if (cur == IDLE) begin
            cur <= nxt;
        end else if (busy) begin
            if (tft_done) begin
                cur  <= nxt;
                busy <= 1'b0;
            end
        end else if (hit) begin
            busy <= 1'b1;
        end else begin
            cur <= nxt;   // nothing to draw, one cycle only
        end
    end

    a_draw_in_button: assert property (@(posedge clk) disable iff (!arstn)
        tft_draw |-> cur != IDLE);

    a_ack_onehot: assert property (@(posedge clk) disable iff (!arstn)
        $onehot0(ack));

endmodule

`default_nettype wire

// ==== hw/bitmap_streamer.sv ====
// bitmap streamer: drawing window and pixel colours for the button being drawn
`default_nettype none
`include "gui_params.svh"

module bitmap_streamer
    import gui_pkg::*;
(
    input  wire                    clk,
    input  wire                    arstn,
    input  wire gui_state_e        cur,
    input  wire                    run_state,
    input  wire                    load,
    input  wire                    cnext,
    output rect_t                  window,
    output logic [`GUI_COLOR_W-1:0] color
);

    localparam int CW    = `GUI_COORD_W;
    localparam int CNT_W = $clog2(`GUI_BMP_W);
    localparam int IDX_W = $clog2(2 * `GUI_BMP_H);

    localparam logic [CW-1:0] WIN_X0 = CW'(`GUI_BTN_X + `GUI_BMP_OFS);
    localparam logic [CW-1:0] WIN_W1 = CW'(`GUI_BMP_W - 1);
    localparam logic [CW-1:0] WIN_H1 = CW'(`GUI_BMP_H - 1);

    localparam logic [CNT_W-1:0] COL_LAST = CNT_W'(`GUI_BMP_W - 1);
    localparam logic [CNT_W-1:0] ROW_LAST = CNT_W'(`GUI_BMP_H - 1);

    logic [CW-1:0]    win_y0;
    logic [CNT_W-1:0] col;
    logic [CNT_W-1:0] row;
    logic [IDX_W-1:0] start_idx;
    bmp_row_t         row_bits;
    logic             pix;

    always_comb begin
        case (cur)
            START:   win_y0 = CW'(`GUI_START_Y + `GUI_BMP_OFS);
            LEFT:    win_y0 = CW'(`GUI_LEFT_Y + `GUI_BMP_OFS);
            RIGHT:   win_y0 = CW'(`GUI_RIGHT_Y + `GUI_BMP_OFS);
            default: win_y0 = '0;
        endcase
    end

    // zero window while idle
    always_comb begin
        if (cur == IDLE) begin
            window = '0;
        end else begin
            window.xstart = WIN_X0;
            window.xend   = WIN_X0 + WIN_W1;
            window.ystart = win_y0;
            window.yend   = win_y0 + WIN_H1;
        end
    end

    // raster order, left to right then down
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            col <= '0;
            row <= '0;
        end else if (load) begin
            col <= '0;
            row <= '0;
        end else if (cnext) begin
            if (col == COL_LAST) begin
                col <= '0;
                row <= (row == ROW_LAST) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // run glyph lives in the second half of the start bitmap
    assign start_idx = IDX_W'(row) + (run_state ? IDX_W'(`GUI_BMP_H) : '0);

    always_comb begin
        case (cur)
            START:   row_bits = bmp_start[start_idx];
            LEFT:    row_bits = bmp_left[row];
            RIGHT:   row_bits = bmp_right[row];
            default: row_bits = '0;
        endcase
    end

    assign pix   = row_bits[COL_LAST - col];
    assign color = pix ? `GUI_COLOR_FG : `GUI_COLOR_BG;

    // the display only asks for pixels inside a button pass
    a_cnext_in_pass: assert property (@(posedge clk) disable iff (!arstn)
        cnext |-> cur != IDLE);

endmodule

`default_nettype wire

// ==== hw/button_touch.sv ====
// touch button: rectangle hit test, optional run-state toggle and redraw request
`default_nettype none
`include "gui_params.svh"

module button_touch
    import gui_pkg::*;
#(
    parameter int unsigned RECT_Y = 0,    // top edge of the touch area
    parameter bit          TOGGLE = 1'b0
) (
    input  wire         clk,
    input  wire         arstn,
    input  wire touch_t touch,
    input  wire         ack,
    output logic        touched,
    output logic        state,
    output logic        pending
);

    localparam int CW = `GUI_COORD_W;
    localparam logic [CW-1:0] X0 = CW'(`GUI_BTN_X);
    localparam logic [CW-1:0] X1 = CW'(`GUI_BTN_X + `GUI_BTN_W);
    localparam logic [CW-1:0] Y0 = CW'(RECT_Y);
    localparam logic [CW-1:0] Y1 = CW'(RECT_Y + `GUI_BTN_H);

    logic hit;
    logic touched_d;
    logic rise;
    logic set_req;

    // end edges are exclusive
    assign hit = touch.touch && (touch.x >= X0) && (touch.x < X1)
                 && (touch.y >= Y0) && (touch.y < Y1);

    assign rise    = touched && !touched_d;
    assign set_req = TOGGLE && rise;   // only a toggling button changes its picture

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            touched   <= 1'b0;
            touched_d <= 1'b0;
        end else begin
            touched   <= hit;
            touched_d <= touched;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state <= 1'b0;   // paused
        end else if (set_req) begin
            state <= !state;
        end
    end

    // redraw everything once after reset
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            pending <= 1'b1;
        end else if (set_req) begin
            pending <= 1'b1;   // wins over a same-cycle ack
        end else if (ack) begin
            pending <= 1'b0;
        end
    end

    // a held touch flips the state only once
    a_state_on_edge: assert property (@(posedge clk) disable iff (!arstn)
        $changed(state) |-> $past(touched && !touched_d));

endmodule

`default_nettype wire

// ==== hw/gui_pkg.sv ====
// gui types: draw state, window rectangle, touch sample and the button bitmaps
`default_nettype none
`include "gui_params.svh"

package gui_pkg;

    // also names the button currently drawn
    typedef enum logic [1:0] {
        IDLE,
        START,
        LEFT,
        RIGHT
    } gui_state_e;

    typedef struct packed {
        logic [`GUI_COORD_W-1:0] xstart;
        logic [`GUI_COORD_W-1:0] xend;
        logic [`GUI_COORD_W-1:0] ystart;
        logic [`GUI_COORD_W-1:0] yend;
    } rect_t;

    typedef struct packed {
        logic                    touch;
        logic [`GUI_COORD_W-1:0] x;
        logic [`GUI_COORD_W-1:0] y;
    } touch_t;

    // bit 19 is the leftmost pixel
    typedef logic [`GUI_BMP_W-1:0] bmp_row_t;

    // rows 0..19 pause glyph, rows 20..39 run glyph
    localparam bmp_row_t bmp_start [2*`GUI_BMP_H] = '{
        20'b00000000000000000000,
        20'b11111111111111111110,
        20'b10000000000000000010,
        20'b01000000000000000100,
        20'b01000000000000000100,
        20'b00100000000000001000,
        20'b00100000000000001000,
        20'b00010000000000010000,
        20'b00010000000000010000,
        20'b00001000000000100000,
        20'b00001000000000100000,
        20'b00000100000001000000,
        20'b00000100000001000000,
        20'b00000010000010000000,
        20'b00000010000010000000,
        20'b00000001000100000000,
        20'b00000001000100000000,
        20'b00000000101000000000,
        20'b00000000101000000000,
        20'b00000000010000000000,
        20'b00000000000000000000,
        20'b00000000000000000000,
        20'b00000000000000000000,
        20'b00111111111111110000,
        20'b00111111111111110000,
        20'b00111111111111110000,
        20'b00000000000000000000,
        20'b00000000000000000000,
        20'b00000000000000000000,
        20'b00000000000000000000,
        20'b00000000000000000000,
        20'b00000000000000000000,
        20'b00000000000000000000,
        20'b00000000000000000000,
        20'b00111111111111110000,
        20'b00111111111111110000,
        20'b00111111111111110000,
        20'b00000000000000000000,
        20'b00000000000000000000,
        20'b00000000000000000000
    };

    // two stacked chevrons
    localparam bmp_row_t bmp_left [`GUI_BMP_H] = '{
        20'b00000000010000000000,
        20'b00000000101000000000,
        20'b00000001000100000000,
        20'b00000010000010000000,
        20'b00000100000001000000,
        20'b00001000000000100000,
        20'b00010000000000010000,
        20'b00100000000000001000,
        20'b01000000000000000100,
        20'b10000000000000000010,
        20'b00000000010000000000,
        20'b00000000101000000000,
        20'b00000001000100000000,
        20'b00000010000010000000,
        20'b00000100000001000000,
        20'b00001000000000100000,
        20'b00010000000000010000,
        20'b00100000000000001000,
        20'b01000000000000000100,
        20'b10000000000000000010
    };

    localparam bmp_row_t bmp_right [`GUI_BMP_H] = '{
        20'b10000000000000000010,
        20'b01000000000000000100,
        20'b00100000000000001000,
        20'b00010000000000010000,
        20'b00001000000000100000,
        20'b00000100000001000000,
        20'b00000010000010000000,
        20'b00000001000100000000,
        20'b00000000101000000000,
        20'b00000000010000000000,
        20'b10000000000000000010,
        20'b01000000000000000100,
        20'b00100000000000001000,
        20'b00010000000000010000,
        20'b00001000000000100000,
        20'b00000100000001000000,
        20'b00000010000010000000,
        20'b00000001000100000000,
        20'b00000000101000000000,
        20'b00000000010000000000
    };

endpackage

`default_nettype wire

// ==== hw/gui_params.svh ====
// gui parameters: coordinate and colour widths, button placement, bitmap geometry and colours
`ifndef GUI_PARAMS_SVH
`define GUI_PARAMS_SVH

// screen coordinates
`define GUI_COORD_W 16

// rgb565
`define GUI_COLOR_W 16

// touch area of one button
`define GUI_BTN_W 40
`define GUI_BTN_H 40

// bitmap sits centred in the touch area
`define GUI_BMP_OFS 10
`define GUI_BMP_W 20
`define GUI_BMP_H 20

// all buttons share one column
`define GUI_BTN_X 10

// top edges
`define GUI_START_Y 110
`define GUI_LEFT_Y 60
`define GUI_RIGHT_Y 260

// set bit is white, clear bit black
`define GUI_COLOR_FG 16'hffff
`define GUI_COLOR_BG 16'h0000

`endif
